/* build.f */
src/mips_pkg.sv
src/stage_reg.sv
src/register_file.sv
src/control_unit.sv
src/alu.sv
src/hazard_unit.sv
src/pipeline_cpu.sv
bench/pipeline_cpu_assertions.sv
bench/tb_pipeline_cpu.sv

/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - src/mips_pkg.sv
  - src/stage_reg.sv
  - src/register_file.sv
  - src/control_unit.sv
  - src/alu.sv
  - src/hazard_unit.sv
  - src/pipeline_cpu.sv
  - target: test
    files:
      - bench/pipeline_cpu_assertions.sv
      - bench/tb_pipeline_cpu.sv

/* bench/tb_pipeline_cpu.sv */
// pipeline core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_cpu
    import mips_pkg::*;
();

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 16;
    localparam int          PROG_LEN        = 27;
    localparam int          LOOP_PC         = 26;
    localparam int          DRAIN_CYCLES    = 5;   // last store and write leave the pipe
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 3 * PROG_LEN + 40;
    localparam logic [31:0] SEED            = 32'h7e5e;

    logic              clk;
    logic              reset;
    logic [XLEN-1:0]   im_addr;
    logic [XLEN-1:0]   im_data;
    logic [XLEN-1:0]   dm_addr;
    logic              dm_we;
    logic [XLEN-1:0]   dm_wdata;
    logic [XLEN-1:0]   dm_rdata;
    logic [REG_AW-1:0] reg_addr;
    logic [XLEN-1:0]   reg_data;

    logic [XLEN-1:0] imem [0:63];
    logic [XLEN-1:0] dmem [0:63];
    logic [XLEN-1:0] ref_mem [0:63];   // sequential model of the data memory
    logic [XLEN-1:0] ref_regs [0:31];
    logic            ref_written [0:31];
    int              error_count = 0;
    int              assert_fails;

    pipeline_cpu i_dut (
        .clk      (clk),
        .reset    (reset),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata),
        .reg_addr (reg_addr),
        .reg_data (reg_data)
    );

    // ******************************
    // memory models
    // ******************************

    assign im_data  = imem[im_addr[5:0]];
    assign dm_rdata = dmem[dm_addr[5:0]];

    always @(posedge clk) begin
        if (dm_we) dmem[dm_addr[5:0]] <= dm_wdata;
    end

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) imem[i] = '0;   // funct 0 decodes as nop
        imem[0]  = encode_i(OP_LW, 0, 1, 16'd0);
        imem[1]  = encode_i(OP_LW, 0, 2, 16'd1);
        imem[2]  = encode_r(1, 2, 3, FN_ADDU);        // load-use on r2
        imem[3]  = encode_r(3, 1, 4, FN_SUBU);
        imem[4]  = encode_r(4, 3, 5, FN_AND);         // memory and writeback forwarding
        imem[5]  = encode_r(5, 4, 6, FN_OR);
        imem[6]  = encode_r(6, 5, 7, FN_SLT);
        imem[7]  = encode_i(OP_ADDIU, 6, 8, 16'hfffb);
        imem[8]  = encode_i(OP_LUI, 0, 9, 16'h1234);
        imem[9]  = encode_i(OP_ADDIU, 0, 10, 16'd12);
        imem[10] = encode_r(9, 8, 0, FN_ADDU);        // write to r0 is dropped
        imem[11] = encode_r(0, 9, 11, FN_ADDU);
        imem[12] = encode_r(3, 4, 12, FN_ADDU);
        imem[13] = encode_i(OP_SW, 10, 12, 16'd3);    // data forwarded from the addu
        imem[14] = encode_i(OP_LW, 10, 13, 16'd3);
        imem[15] = encode_r(13, 0, 14, FN_ADDU);
        imem[16] = encode_r(9, 0, 15, FN_ADDU);
        imem[17] = encode_i(OP_BEQ, 15, 11, 16'd1);   // taken, right after its addu
        imem[18] = encode_i(OP_ADDIU, 15, 15, 16'd1);
        imem[19] = encode_i(OP_ADDIU, 0, 17, 16'd2);
        imem[20] = encode_i(OP_LW, 0, 18, 16'd0);
        imem[21] = encode_i(OP_BEQ, 18, 1, 16'd1);    // taken, right after its lw
        imem[22] = encode_i(OP_ADDIU, 18, 18, 16'd1);
        imem[23] = encode_i(OP_BEQ, 1, 2, 16'd1);     // untaken unless the words match
        imem[24] = encode_i(OP_ADDIU, 0, 20, 16'd4);
        imem[25] = encode_i(OP_SW, 10, 14, 16'd4);
        imem[26] = encode_i(OP_BEQ, 0, 0, 16'hffff);  // self-loop
    endtask

    // one instruction at a time, straight from the isa rules
    task automatic run_reference();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc_ref;
        pc_ref = '0;
        for (int step = 0; step < 4 * PROG_LEN; step++) begin
            instr = imem[pc_ref[5:0]];
            if (pc_ref == LOOP_PC) break;
            a      = ref_regs[instr[25:21]];
            b      = ref_regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            pc_ref = pc_ref + 1;
            case (instr[31:26])
                OP_RTYPE: begin
                    ref_written[instr[15:11]] = 1'b1;
                    case (instr[5:0])
                        FN_ADDU: ref_regs[instr[15:11]] = a + b;
                        FN_SUBU: ref_regs[instr[15:11]] = a - b;
                        FN_AND:  ref_regs[instr[15:11]] = a & b;
                        FN_OR:   ref_regs[instr[15:11]] = a | b;
                        FN_SLT:  ref_regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ref_written[instr[15:11]] = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    ref_regs[instr[20:16]]    = a + imm;
                    ref_written[instr[20:16]] = 1'b1;
                end
                OP_LUI: begin
                    ref_regs[instr[20:16]]    = {instr[15:0], 16'h0000};
                    ref_written[instr[20:16]] = 1'b1;
                end
                OP_LW: begin
                    ref_regs[instr[20:16]]    = ref_mem[(a + imm) % 64];
                    ref_written[instr[20:16]] = 1'b1;
                end
                OP_SW:   ref_mem[(a + imm) % 64] = b;
                OP_BEQ:  if (a == b) pc_ref = pc_ref + imm;
                default: ;
            endcase
            ref_regs[0] = '0;
        end
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // ******************************
    // clock, watchdog and main flow
    // ******************************

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the program never reached its final loop");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        reg_addr = '0;   // pc on the debug port while running
        void'($urandom(SEED));
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = $urandom();
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i]    = '0;
            ref_written[i] = 1'b0;
        end
        load_program();
        run_reference();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (reg_data !== LOOP_PC) @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);
        for (int r = 1; r < 32; r++) begin
            @(negedge clk);
            reg_addr = r;
            @(posedge clk);
            if (ref_written[r]) check_value($sformatf("register r%0d", r), ref_regs[r], reg_data);
        end
        for (int i = 0; i < 64; i++) begin
            check_value($sformatf("data word %0d", i), ref_mem[i], dmem[i]);
        end
        assert_fails = i_dut.i_pipeline_cpu_assertions.fail_count;
        $display("value errors: %0d, assertion failures: %0d", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/pipeline_cpu_assertions.sv */
// pipeline core assertions
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu_assertions
    import mips_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic [XLEN-1:0]   im_addr,
    input logic              dm_we,
    input logic [5:0]        decode_opcode,    // opcode sitting in decode
    input logic [REG_AW-1:0] decode_rs,
    input logic [REG_AW-1:0] decode_rt,
    input logic              load_in_exec,     // lw sitting in execute
    input logic [REG_AW-1:0] exec_rt,          // lw destination
    input logic              branch_in_decode,
    input logic              stall
);

    int   fail_count = 0;
    logic load_use;

    // a branch after a load may stall twice, so only plain readers count
    assign load_use = load_in_exec && !branch_in_decode && (exec_rt != '0)
                      && (decode_rs == exec_rt || decode_rt == exec_rt);

    // fetch starts at word 0 with no store pending
    reset_state: assert property (@(posedge clk) reset |=> (im_addr == '0) && !dm_we)
        else begin fail_count++; $error("pc or store enable wrong after reset"); end

    // a sw leaving decode is the only source of a store two cycles later
    store_origin: assert property (@(posedge clk) disable iff (reset)
        dm_we == $past(decode_opcode == OP_SW && !stall, 2))
        else begin fail_count++; $error("store enable does not match a sw leaving decode"); end

    load_use_hold: assert property (@(posedge clk) disable iff (reset)
        load_use |=> im_addr == $past(im_addr))
        else begin fail_count++; $error("fetch address moved during a load-use stall"); end

    load_use_single: assert property (@(posedge clk) disable iff (reset)
        load_use |=> ##1 im_addr != $past(im_addr))
        else begin fail_count++; $error("load-use stall lasted more than one cycle"); end

endmodule

bind pipeline_cpu pipeline_cpu_assertions i_pipeline_cpu_assertions (
    .clk              (clk),
    .reset            (reset),
    .im_addr          (im_addr),
    .dm_we            (dm_we),
    .decode_opcode    (fd_q.instr[31:26]),
    .decode_rs        (rs_d),
    .decode_rt        (rt_d),
    .load_in_exec     (de_q.ctrl.mem_to_reg),
    .exec_rt          (de_q.rt),
    .branch_in_decode (branch_d),
    .stall            (stall)
);

`default_nettype wire

/* src/pipeline_cpu.sv */
// five stage mips core
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu
    import mips_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    output logic [XLEN-1:0]   im_addr,    // word index
    input  logic [XLEN-1:0]   im_data,
    output logic [XLEN-1:0]   dm_addr,
    output logic              dm_we,
    output logic [XLEN-1:0]   dm_wdata,
    input  logic [XLEN-1:0]   dm_rdata,
    input  logic [REG_AW-1:0] reg_addr,   // zero selects the pc
    output logic [XLEN-1:0]   reg_data
);

    // fetch
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   pc_next_f;
    logic [XLEN-1:0]   pc_branch_d;
    logic              stall;
    logic              redirect;   // taken beq, not held by a stall

    // decode
    logic [REG_AW-1:0] rs_d;
    logic [REG_AW-1:0] rt_d;
    logic [REG_AW-1:0] rd_d;
    logic [XLEN-1:0]   sign_imm_d;
    logic [XLEN-1:0]   rd1_d;
    logic [XLEN-1:0]   rd2_d;
    logic [XLEN-1:0]   cmp_a_d;
    logic [XLEN-1:0]   cmp_b_d;
    logic [XLEN-1:0]   dbg_data;
    ctrl_t             ctrl_d;
    logic              branch_d;
    logic              pc_src;
    logic              fwd_a_d;
    logic              fwd_b_d;

    // execute
    fwd_sel_t          fwd_a_e;
    fwd_sel_t          fwd_b_e;
    logic [XLEN-1:0]   src_a_e;
    logic [XLEN-1:0]   src_b_e;
    logic [XLEN-1:0]   write_data_e;
    logic [XLEN-1:0]   alu_result_e;
    logic [REG_AW-1:0] write_reg_e;

    // writeback
    logic [XLEN-1:0]   write_data_w;

    fd_border_t fd_d, fd_q;
    de_border_t de_d, de_q;
    em_border_t em_d, em_q;
    mw_border_t mw_d, mw_q;

    // picks the live value of an execute operand
    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] mem_val,
                                                input logic [XLEN-1:0] wb_val);
        logic [XLEN-1:0] value;
        case (sel)
            FWD_MEM: value = mem_val;
            FWD_WB:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    // ******************************
    // fetch
    // ******************************

    assign pc_next_f = pc + XLEN'(1);   // pc counts words
    assign im_addr   = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= redirect ? pc_branch_d : pc_next_f;
        end
    end

    assign fd_d = '{pc_next: pc_next_f, instr: im_data};

    stage_reg #(.payload_t(fd_border_t)) i_fd_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (!stall),
        .flush  (redirect),   // drop the slot after a taken beq
        .d      (fd_d),
        .q      (fd_q)
    );

    // ******************************
    // decode
    // ******************************

    assign rs_d       = fd_q.instr[25:21];
    assign rt_d       = fd_q.instr[20:16];
    assign rd_d       = fd_q.instr[15:11];
    assign sign_imm_d = {{16{fd_q.instr[15]}}, fd_q.instr[15:0]};

    register_file i_register_file (
        .clk      (clk),
        .rs_addr  (rs_d),
        .rt_addr  (rt_d),
        .dbg_addr (reg_addr),
        .wr_addr  (mw_q.write_reg),
        .wr_data  (write_data_w),
        .wr_en    (mw_q.reg_write),
        .rs_data  (rd1_d),
        .rt_data  (rd2_d),
        .dbg_data (dbg_data)
    );

    assign reg_data = (reg_addr != '0) ? dbg_data : pc;

    // early branch resolution
    assign cmp_a_d     = fwd_a_d ? em_q.alu_result : rd1_d;
    assign cmp_b_d     = fwd_b_d ? em_q.alu_result : rd2_d;
    assign pc_branch_d = fd_q.pc_next + sign_imm_d;

    control_unit i_control_unit (
        .instr      (fd_q.instr),
        .regs_equal (cmp_a_d == cmp_b_d),
        .ctrl       (ctrl_d),
        .branch     (branch_d),
        .pc_src     (pc_src)
    );

    // a stalled beq compares stale operands, so wait for the stall to clear
    assign redirect = pc_src && !stall;

    assign de_d = '{ctrl: ctrl_d, rd1: rd1_d, rd2: rd2_d, sign_imm: sign_imm_d,
                    rs: rs_d, rt: rt_d, rd: rd_d};

    stage_reg #(.payload_t(de_border_t)) i_de_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (stall),   // bubble into execute
        .d      (de_d),
        .q      (de_q)
    );

    // ******************************
    // execute
    // ******************************

    assign src_a_e      = fwd_mux(fwd_a_e, de_q.rd1, em_q.alu_result, write_data_w);
    assign write_data_e = fwd_mux(fwd_b_e, de_q.rd2, em_q.alu_result, write_data_w);
    assign src_b_e      = de_q.ctrl.alu_src ? de_q.sign_imm : write_data_e;

    alu i_alu (
        .src_a  (src_a_e),
        .src_b  (src_b_e),
        .op     (de_q.ctrl.alu_op),
        .result (alu_result_e)
    );

    // ******************************
    // destination select
    // ******************************

    assign write_reg_e = de_q.ctrl.reg_dst ? de_q.rd : de_q.rt;

    assign em_d = '{reg_write: de_q.ctrl.reg_write, mem_write: de_q.ctrl.mem_write,
                    mem_to_reg: de_q.ctrl.mem_to_reg, alu_result: alu_result_e,
                    write_data: write_data_e, write_reg: write_reg_e};

    stage_reg #(.payload_t(em_border_t)) i_em_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (1'b0),
        .d      (em_d),
        .q      (em_q)
    );

    // ******************************
    // memory
    // ******************************

    assign dm_addr  = em_q.alu_result;
    assign dm_we    = em_q.mem_write;
    assign dm_wdata = em_q.write_data;

    assign mw_d = '{reg_write: em_q.reg_write, mem_to_reg: em_q.mem_to_reg,
                    alu_result: em_q.alu_result, read_data: dm_rdata,
                    write_reg: em_q.write_reg};

    stage_reg #(.payload_t(mw_border_t)) i_mw_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (1'b0),
        .d      (mw_d),
        .q      (mw_q)
    );

    // ******************************
    // writeback select
    // ******************************

    assign write_data_w = mw_q.mem_to_reg ? mw_q.read_data : mw_q.alu_result;

    hazard_unit i_hazard_unit (
        .rs_d         (rs_d),
        .rt_d         (rt_d),
        .rs_e         (de_q.rs),
        .rt_e         (de_q.rt),
        .write_reg_e  (write_reg_e),
        .write_reg_m  (em_q.write_reg),
        .write_reg_w  (mw_q.write_reg),
        .reg_write_e  (de_q.ctrl.reg_write),
        .reg_write_m  (em_q.reg_write),
        .reg_write_w  (mw_q.reg_write),
        .mem_to_reg_e (de_q.ctrl.mem_to_reg),
        .mem_to_reg_m (em_q.mem_to_reg),
        .branch_d     (branch_d),
        .fwd_a_e      (fwd_a_e),
        .fwd_b_e      (fwd_b_e),
        .fwd_a_d      (fwd_a_d),
        .fwd_b_d      (fwd_b_d),
        .stall        (stall)
    );

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
// forwarding and stall control
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import mips_pkg::*;
(
    input  logic [REG_AW-1:0] rs_d,
    input  logic [REG_AW-1:0] rt_d,
    input  logic [REG_AW-1:0] rs_e,
    input  logic [REG_AW-1:0] rt_e,
    input  logic [REG_AW-1:0] write_reg_e,
    input  logic [REG_AW-1:0] write_reg_m,
    input  logic [REG_AW-1:0] write_reg_w,
    input  logic              reg_write_e,
    input  logic              reg_write_m,
    input  logic              reg_write_w,
    input  logic              mem_to_reg_e,
    input  logic              mem_to_reg_m,
    input  logic              branch_d,
    output fwd_sel_t          fwd_a_e,
    output fwd_sel_t          fwd_b_e,
    output logic              fwd_a_d,
    output logic              fwd_b_d,
    output logic              stall
);

    logic load_use;
    logic branch_wait_alu;    // beq source still in execute
    logic branch_wait_load;   // beq source loaded in memory

    // memory stage is younger, so it wins over writeback
    function automatic fwd_sel_t exec_fwd(input logic [REG_AW-1:0] src);
        fwd_sel_t sel;
        if (src == '0) begin
            sel = FWD_NONE;
        end else if (reg_write_m && src == write_reg_m) begin
            sel = FWD_MEM;
        end else if (reg_write_w && src == write_reg_w) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    // decode reads dst through rs or rt
    function automatic logic reads(input logic [REG_AW-1:0] a, input logic [REG_AW-1:0] b,
                                   input logic [REG_AW-1:0] dst);
        return (dst != '0) && (a == dst || b == dst);
    endfunction

    always_comb begin
        fwd_a_e = exec_fwd(rs_e);
        fwd_b_e = exec_fwd(rt_e);
    end

    // branch compare taps the memory stage alu result
    assign fwd_a_d = (rs_d != '0) && reg_write_m && (rs_d == write_reg_m);
    assign fwd_b_d = (rt_d != '0) && reg_write_m && (rt_d == write_reg_m);

    assign load_use         = mem_to_reg_e && reads(rs_d, rt_d, write_reg_e);
    assign branch_wait_alu  = branch_d && reg_write_e && reads(rs_d, rt_d, write_reg_e);
    assign branch_wait_load = branch_d && mem_to_reg_m && reads(rs_d, rt_d, write_reg_m);

    assign stall = load_use || branch_wait_alu || branch_wait_load;

endmodule

`default_nettype wire

/* src/alu.sv */
// mips integer alu
`timescale 1ns/1ps
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] src_a,
    input  logic [XLEN-1:0] src_b,
    input  alu_op_t         op,
    output logic [XLEN-1:0] result
);

    logic less_than;

    assign less_than = $signed(src_a) < $signed(src_b);   // slt is signed

    always_comb begin
        case (op)
            ALU_ADD: result = src_a + src_b;
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, less_than};
            ALU_LUI: result = src_b << 16;   // immediate into upper half
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/control_unit.sv */
// mips main decoder
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] instr,
    input  logic            regs_equal,   // forwarded compare from decode
    output ctrl_t           ctrl,
    output logic            branch,
    output logic            pc_src
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl   = '0;
        branch = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl = '0;   // unknown funct runs as nop
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_LUI;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;   // base plus offset
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                branch = 1'b1;   // resolved here, nothing goes down the pipe
            end
            default: begin
                ctrl   = '0;
                branch = 1'b0;
            end
        endcase
    end

    assign pc_src = branch && regs_equal;

endmodule

`default_nettype wire

/* src/register_file.sv */
// mips register file
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] rs_addr,
    input  logic [REG_AW-1:0] rt_addr,
    input  logic [REG_AW-1:0] dbg_addr,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic              wr_en,
    output logic [XLEN-1:0]   rs_data,
    output logic [XLEN-1:0]   rt_data,
    output logic [XLEN-1:0]   dbg_data
);

    logic [XLEN-1:0] regs [1:31];   // r0 has no storage

    // r0 reads zero, a same-cycle write is passed straight through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wr_addr == addr) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data  = read_port(rs_addr);
        rt_data  = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* src/stage_reg.sv */
// pipeline border register
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,   // low holds the border
    input  logic     flush,    // loads a bubble
    input  payload_t d,
    output payload_t q
);

    // flush wins over a held enable
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
// mips core shared types
`default_nettype none

package mips_pkg;

    localparam int XLEN   = 32;   // data and address width
    localparam int REG_AW = 5;    // register address width

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field of r-type
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    // all zero is a nop
    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;     // rd instead of rt
        logic    alu_src;     // immediate as operand b
        alu_op_t alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc_next;
        logic [XLEN-1:0] instr;
    } fd_border_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   rd1;
        logic [XLEN-1:0]   rd2;
        logic [XLEN-1:0]   sign_imm;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
    } de_border_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_write;
        logic              mem_to_reg;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   write_data;  // store data, already forwarded
        logic [REG_AW-1:0] write_reg;
    } em_border_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   read_data;
        logic [REG_AW-1:0] write_reg;
    } mw_border_t;

endpackage

`default_nettype wire
